// ==== common/p3_buf_pkg.sv ====
package p3_buf_pkg;

    // Packet word as seen by the snooper and the forwarder
    localparam int DATA_WIDTH = 64;

    // Valid bytes added to the packet length by one snooper write
    localparam int INC_WIDTH = 8;

    // Running packet byte length kept by each buffer
    localparam int PLEN_WIDTH = 32;

    // One packet word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Byte increment carried with each write
    typedef logic [INC_WIDTH-1:0] inc_t;

    // Packet length in bytes
    typedef logic [PLEN_WIDTH-1:0] plen_t;

endpackage

// ==== common/p3_ctrl_pkg.sv ====
package p3_ctrl_pkg;

    // Ping, pang and pong
    localparam int NUM_BUFS = 3;

    // Life cycle of one buffer, in the order it is walked through
    typedef enum logic [1:0] {
        BUF_FREE     = 2'd0,
        BUF_FILLING  = 2'd1,
        BUF_FULL     = 2'd2,
        BUF_DRAINING = 2'd3
    } buf_state_t;

    // Buffer index: 0 is ping, 1 is pang, 2 is pong
    typedef logic [1:0] buf_sel_t;

    // No buffer owned
    localparam buf_sel_t SEL_NONE = 2'd3;

endpackage

// ==== p3ctrl/p3ctrl.sv ====
`timescale 1ns/10ps

module p3ctrl import p3_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                sn_start_ack_i,
    input  logic                sn_done_i,
    input  logic                fwd_start_ack_i,
    input  logic                fwd_done_i,
    output logic                rdy_for_sn_o,
    output logic                sn_done_ack_o,
    output logic                rdy_for_fwd_o,
    output logic                fwd_done_ack_o,
    output buf_sel_t            sn_sel_o,
    output buf_sel_t            fwd_sel_o,
    output logic [NUM_BUFS-1:0] clr_len_o
);

    buf_state_t state_q [NUM_BUFS];
    buf_state_t state_d [NUM_BUFS];

    // Full buffers in the order they were filled, oldest at slot 0
    buf_sel_t   order_q [NUM_BUFS];
    buf_sel_t   order_d [NUM_BUFS];
    logic [1:0] cnt_q;
    logic [1:0] cnt_d;

    buf_sel_t   free_sel;
    logic       sn_start;
    logic       fwd_start;
    logic       sn_push;
    logic       fwd_free;
    logic       any_free_d;
    logic       any_filling_d;
    logic       any_draining_d;

    // At most one buffer fills and one drains, so the owners are just lookups
    always_comb begin
        sn_sel_o  = SEL_NONE;
        fwd_sel_o = SEL_NONE;
        free_sel  = SEL_NONE;
        for (int i = NUM_BUFS - 1; i >= 0; i--) begin
            if (state_q[i] == BUF_FILLING)
                sn_sel_o = buf_sel_t'(i);
            if (state_q[i] == BUF_DRAINING)
                fwd_sel_o = buf_sel_t'(i);
            // Walking downwards leaves the lowest free index
            if (state_q[i] == BUF_FREE)
                free_sel = buf_sel_t'(i);
        end
    end

    assign sn_start  = sn_start_ack_i && rdy_for_sn_o;
    assign fwd_start = fwd_start_ack_i && rdy_for_fwd_o;
    assign sn_push   = sn_done_i && (sn_sel_o != SEL_NONE);
    assign fwd_free  = fwd_done_i && (fwd_sel_o != SEL_NONE);

    // Length clear goes out on the ack cycle itself
    always_comb begin
        clr_len_o = '0;
        if (sn_start)
            clr_len_o[free_sel] = 1'b1;
    end

    always_comb begin
        state_d = state_q;
        order_d = order_q;
        cnt_d   = cnt_q;

        if (sn_start)
            state_d[free_sel] = BUF_FILLING;
        if (sn_push)
            state_d[sn_sel_o] = BUF_FULL;
        if (fwd_start)
            state_d[order_q[0]] = BUF_DRAINING;
        if (fwd_free)
            state_d[fwd_sel_o] = BUF_FREE;

        // Pop first so a push in the same cycle lands behind the remaining entries
        if (fwd_start) begin
            order_d[0] = order_q[1];
            order_d[1] = order_q[2];
            order_d[2] = SEL_NONE;
            cnt_d      = cnt_d - 2'd1;
        end
        if (sn_push) begin
            order_d[cnt_d] = sn_sel_o;
            cnt_d          = cnt_d + 2'd1;
        end
    end

    always_comb begin
        any_free_d     = 1'b0;
        any_filling_d  = 1'b0;
        any_draining_d = 1'b0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            any_free_d     |= (state_d[i] == BUF_FREE);
            any_filling_d  |= (state_d[i] == BUF_FILLING);
            any_draining_d |= (state_d[i] == BUF_DRAINING);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                state_q[i] <= BUF_FREE;
                order_q[i] <= SEL_NONE;
            end
            cnt_q          <= '0;
            rdy_for_sn_o   <= 1'b0;
            rdy_for_fwd_o  <= 1'b0;
            sn_done_ack_o  <= 1'b0;
            fwd_done_ack_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            order_q        <= order_d;
            cnt_q          <= cnt_d;
            // Levels follow the next state, so they drop right after an ack
            rdy_for_sn_o   <= any_free_d && !any_filling_d;
            rdy_for_fwd_o  <= (cnt_d != 2'd0) && !any_draining_d;
            sn_done_ack_o  <= sn_push;
            fwd_done_ack_o <= fwd_free;
        end
    end

endmodule

// ==== p_ng/p_ng.sv ====
`timescale 1ns/10ps

module p_ng import p3_buf_pkg::*; #(
    parameter int unsigned ADDR_WIDTH = 10,
    parameter bit          BUF_OUT    = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  clr_len_i,
    input  logic                  rd_en_i,
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  data_t                 wr_data_i,
    input  inc_t                  byte_inc_i,
    output data_t                 rd_data_o,
    output logic                  rd_data_vld_o,
    output plen_t                 byte_len_o
);

    data_t mem [2**ADDR_WIDTH];
    data_t rd_data_q;
    logic  rd_vld_q;

    // Single port: the address is shared by reads and writes
    always_ff @(posedge clk) begin
        if (wr_en_i)
            mem[addr_i] <= wr_data_i;
        if (rd_en_i)
            rd_data_q <= mem[addr_i];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            rd_vld_q <= 1'b0;
        else
            rd_vld_q <= rd_en_i;
    end

    // Length restarts with each new fill, stored words stay
    always_ff @(posedge clk) begin
        if (!rst_n_i || clr_len_i)
            byte_len_o <= '0;
        else if (wr_en_i)
            byte_len_o <= byte_len_o + plen_t'(byte_inc_i);
    end

    generate
        if (BUF_OUT) begin : g_out_reg
            data_t rd_data_q2;
            logic  rd_vld_q2;

            always_ff @(posedge clk) begin
                rd_data_q2 <= rd_data_q;
            end

            always_ff @(posedge clk) begin
                if (!rst_n_i)
                    rd_vld_q2 <= 1'b0;
                else
                    rd_vld_q2 <= rd_vld_q;
            end

            assign rd_data_o     = rd_data_q2;
            assign rd_data_vld_o = rd_vld_q2;
        end else begin : g_no_out_reg
            assign rd_data_o     = rd_data_q;
            assign rd_data_vld_o = rd_vld_q;
        end
    endgenerate

endmodule

// ==== verilog/buf_mux.sv ====
`timescale 1ns/10ps

module buf_mux import p3_buf_pkg::*, p3_ctrl_pkg::*; #(
    parameter int unsigned ADDR_WIDTH = 10
) (
    input  buf_sel_t                             sn_sel_i,
    input  buf_sel_t                             fwd_sel_i,

    // Snooper stream after the input stage
    input  logic [ADDR_WIDTH-1:0]                sn_addr_i,
    input  logic                                 sn_wr_en_i,

    // Forwarder read request
    input  logic [ADDR_WIDTH-1:0]                fwd_addr_i,
    input  logic                                 fwd_rd_en_i,

    // Toward the buffers
    output logic [NUM_BUFS-1:0]                  buf_wr_en_o,
    output logic [NUM_BUFS-1:0]                  buf_rd_en_o,
    output logic [NUM_BUFS-1:0][ADDR_WIDTH-1:0]  buf_addr_o,

    // From the buffers
    input  data_t [NUM_BUFS-1:0]                 buf_rd_data_i,
    input  logic [NUM_BUFS-1:0]                  buf_rd_vld_i,
    input  plen_t [NUM_BUFS-1:0]                 buf_byte_len_i,

    // Toward the forwarder output stage
    output data_t                                rd_data_o,
    output logic                                 rd_data_vld_o,
    output plen_t                                byte_len_o
);

    // Snooper owns the address of the buffer it fills, the forwarder the rest
    always_comb begin
        for (int i = 0; i < NUM_BUFS; i++) begin
            buf_wr_en_o[i] = sn_wr_en_i && (sn_sel_i == buf_sel_t'(i));
            buf_rd_en_o[i] = fwd_rd_en_i && (fwd_sel_i == buf_sel_t'(i));
            buf_addr_o[i]  = (sn_sel_i == buf_sel_t'(i)) ? sn_addr_i : fwd_addr_i;
        end
    end

    // Read data lags the select, so steer it by the buffer's own valid flag
    always_comb begin
        rd_data_o  = '0;
        byte_len_o = '0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            if (buf_rd_vld_i[i])
                rd_data_o = buf_rd_data_i[i];
            if (fwd_sel_i == buf_sel_t'(i))
                byte_len_o = buf_byte_len_i[i];
        end
    end

    assign rd_data_vld_o = |buf_rd_vld_i;

endmodule

// ==== verilog/sn_adapter.sv ====
`timescale 1ns/10ps

module sn_adapter import p3_buf_pkg::*; #(
    parameter int unsigned ADDR_WIDTH = 10,
    parameter bit          BUF_IN     = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [ADDR_WIDTH-1:0] sn_addr_i,
    input  data_t                 sn_wr_data_i,
    input  logic                  sn_wr_en_i,
    input  inc_t                  sn_byte_inc_i,
    input  logic                  sn_done_i,
    output logic [ADDR_WIDTH-1:0] addr_o,
    output data_t                 wr_data_o,
    output logic                  wr_en_o,
    output inc_t                  byte_inc_o,
    output logic                  done_o
);

    generate
        if (BUF_IN) begin : g_in_reg
            // Done shares the stage with the writes so it cannot overtake them
            always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                    wr_en_o <= 1'b0;
                    done_o  <= 1'b0;
                end else begin
                    wr_en_o <= sn_wr_en_i;
                    done_o  <= sn_done_i;
                end
            end

            always_ff @(posedge clk) begin
                addr_o     <= sn_addr_i;
                wr_data_o  <= sn_wr_data_i;
                byte_inc_o <= sn_byte_inc_i;
            end
        end else begin : g_pass
            assign addr_o     = sn_addr_i;
            assign wr_data_o  = sn_wr_data_i;
            assign wr_en_o    = sn_wr_en_i;
            assign byte_inc_o = sn_byte_inc_i;
            assign done_o     = sn_done_i;
        end
    endgenerate

endmodule

// ==== verilog/fwd_adapter.sv ====
`timescale 1ns/10ps

module fwd_adapter import p3_buf_pkg::*; #(
    parameter bit PESS = 1'b0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  data_t rd_data_i,
    input  logic  rd_data_vld_i,
    input  plen_t byte_len_i,
    output data_t fwd_rd_data_o,
    output logic  fwd_rd_data_vld_o,
    output plen_t fwd_byte_len_o
);

    generate
        if (PESS) begin : g_out_reg
            always_ff @(posedge clk) begin
                if (!rst_n_i)
                    fwd_rd_data_vld_o <= 1'b0;
                else
                    fwd_rd_data_vld_o <= rd_data_vld_i;
            end

            // Length moves with the data so both reach the forwarder together
            always_ff @(posedge clk) begin
                fwd_rd_data_o  <= rd_data_i;
                fwd_byte_len_o <= byte_len_i;
            end
        end else begin : g_pass
            assign fwd_rd_data_o     = rd_data_i;
            assign fwd_rd_data_vld_o = rd_data_vld_i;
            assign fwd_byte_len_o    = byte_len_i;
        end
    endgenerate

endmodule

// ==== verilog/p3.sv ====
`timescale 1ns/10ps

module p3 import p3_buf_pkg::*, p3_ctrl_pkg::*; #(
    parameter int unsigned ADDR_WIDTH = 10,
    parameter bit          BUF_IN     = 1'b0,
    parameter bit          BUF_OUT    = 1'b0,
    parameter bit          PESS       = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // Snooper
    input  logic [ADDR_WIDTH-1:0] sn_addr_i,
    input  data_t                 sn_wr_data_i,
    input  logic                  sn_wr_en_i,
    input  inc_t                  sn_byte_inc_i,
    input  logic                  sn_done_i,
    output logic                  sn_done_ack_o,
    output logic                  rdy_for_sn_o,
    input  logic                  rdy_for_sn_ack_i,

    // Forwarder
    input  logic [ADDR_WIDTH-1:0] fwd_addr_i,
    input  logic                  fwd_rd_en_i,
    output data_t                 fwd_rd_data_o,
    output logic                  fwd_rd_data_vld_o,
    output plen_t                 fwd_byte_len_o,
    input  logic                  fwd_done_i,
    output logic                  fwd_done_ack_o,
    output logic                  rdy_for_fwd_o,
    input  logic                  rdy_for_fwd_ack_i
);

    // Snooper stream after the input stage
    logic [ADDR_WIDTH-1:0]               sn_addr;
    data_t                               sn_wr_data;
    logic                                sn_wr_en;
    inc_t                                sn_byte_inc;
    logic                                sn_done;

    buf_sel_t                            sn_sel;
    buf_sel_t                            fwd_sel;
    logic [NUM_BUFS-1:0]                 clr_len;

    logic [NUM_BUFS-1:0]                 buf_wr_en;
    logic [NUM_BUFS-1:0]                 buf_rd_en;
    logic [NUM_BUFS-1:0][ADDR_WIDTH-1:0] buf_addr;
    data_t [NUM_BUFS-1:0]                buf_rd_data;
    logic [NUM_BUFS-1:0]                 buf_rd_vld;
    plen_t [NUM_BUFS-1:0]                buf_byte_len;

    // Forwarder return path before the output stage
    data_t                               rd_data;
    logic                                rd_data_vld;
    plen_t                               byte_len;

    sn_adapter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_IN     (BUF_IN)
    ) sn_adapter_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .sn_addr_i     (sn_addr_i),
        .sn_wr_data_i  (sn_wr_data_i),
        .sn_wr_en_i    (sn_wr_en_i),
        .sn_byte_inc_i (sn_byte_inc_i),
        .sn_done_i     (sn_done_i),
        .addr_o        (sn_addr),
        .wr_data_o     (sn_wr_data),
        .wr_en_o       (sn_wr_en),
        .byte_inc_o    (sn_byte_inc),
        .done_o        (sn_done)
    );

    p3ctrl p3ctrl_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .sn_start_ack_i  (rdy_for_sn_ack_i),
        .sn_done_i       (sn_done),
        .fwd_start_ack_i (rdy_for_fwd_ack_i),
        .fwd_done_i      (fwd_done_i),
        .rdy_for_sn_o    (rdy_for_sn_o),
        .sn_done_ack_o   (sn_done_ack_o),
        .rdy_for_fwd_o   (rdy_for_fwd_o),
        .fwd_done_ack_o  (fwd_done_ack_o),
        .sn_sel_o        (sn_sel),
        .fwd_sel_o       (fwd_sel),
        .clr_len_o       (clr_len)
    );

    buf_mux #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) buf_mux_inst (
        .sn_sel_i       (sn_sel),
        .fwd_sel_i      (fwd_sel),
        .sn_addr_i      (sn_addr),
        .sn_wr_en_i     (sn_wr_en),
        .fwd_addr_i     (fwd_addr_i),
        .fwd_rd_en_i    (fwd_rd_en_i),
        .buf_wr_en_o    (buf_wr_en),
        .buf_rd_en_o    (buf_rd_en),
        .buf_addr_o     (buf_addr),
        .buf_rd_data_i  (buf_rd_data),
        .buf_rd_vld_i   (buf_rd_vld),
        .buf_byte_len_i (buf_byte_len),
        .rd_data_o      (rd_data),
        .rd_data_vld_o  (rd_data_vld),
        .byte_len_o     (byte_len)
    );

    // Write data and increment reach all buffers, only the strobe is steered
    p_ng #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_OUT    (BUF_OUT)
    ) ping (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .clr_len_i     (clr_len[0]),
        .rd_en_i       (buf_rd_en[0]),
        .wr_en_i       (buf_wr_en[0]),
        .addr_i        (buf_addr[0]),
        .wr_data_i     (sn_wr_data),
        .byte_inc_i    (sn_byte_inc),
        .rd_data_o     (buf_rd_data[0]),
        .rd_data_vld_o (buf_rd_vld[0]),
        .byte_len_o    (buf_byte_len[0])
    );

    p_ng #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_OUT    (BUF_OUT)
    ) pang (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .clr_len_i     (clr_len[1]),
        .rd_en_i       (buf_rd_en[1]),
        .wr_en_i       (buf_wr_en[1]),
        .addr_i        (buf_addr[1]),
        .wr_data_i     (sn_wr_data),
        .byte_inc_i    (sn_byte_inc),
        .rd_data_o     (buf_rd_data[1]),
        .rd_data_vld_o (buf_rd_vld[1]),
        .byte_len_o    (buf_byte_len[1])
    );

    p_ng #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_OUT    (BUF_OUT)
    ) pong (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .clr_len_i     (clr_len[2]),
        .rd_en_i       (buf_rd_en[2]),
        .wr_en_i       (buf_wr_en[2]),
        .addr_i        (buf_addr[2]),
        .wr_data_i     (sn_wr_data),
        .byte_inc_i    (sn_byte_inc),
        .rd_data_o     (buf_rd_data[2]),
        .rd_data_vld_o (buf_rd_vld[2]),
        .byte_len_o    (buf_byte_len[2])
    );

    fwd_adapter #(
        .PESS (PESS)
    ) fwd_adapter_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .rd_data_i         (rd_data),
        .rd_data_vld_i     (rd_data_vld),
        .byte_len_i        (byte_len),
        .fwd_rd_data_o     (fwd_rd_data_o),
        .fwd_rd_data_vld_o (fwd_rd_data_vld_o),
        .fwd_byte_len_o    (fwd_byte_len_o)
    );

endmodule

// ==== sim/p3_tb.sv ====
`timescale 1ns/10ps

module p3_tb import p3_buf_pkg::*; ;

    localparam int ADDR_WIDTH = 10;
    localparam int NUM_ROWS   = 9;
    localparam int WAIT_LIMIT = 50;

    // Row modes are fill only, fill then drain all, and fill beside a drain of the oldest
    localparam logic [1:0] MODE_FILL    = 2'd0;
    localparam logic [1:0] MODE_DRAIN   = 2'd1;
    localparam logic [1:0] MODE_OVERLAP = 2'd2;

    typedef struct packed {
        logic [7:0]  words;
        inc_t        inc;
        logic [1:0]  mode;
        plen_t       exp_len;
        logic [2:0]  behavior;
    } row_t;

    logic                  clk;
    logic                  rst_n_i;
    logic [ADDR_WIDTH-1:0] sn_addr_i;
    data_t                 sn_wr_data_i;
    logic                  sn_wr_en_i;
    inc_t                  sn_byte_inc_i;
    logic                  sn_done_i;
    logic                  sn_done_ack_o;
    logic                  rdy_for_sn_o;
    logic                  rdy_for_sn_ack_i;
    logic [ADDR_WIDTH-1:0] fwd_addr_i;
    logic                  fwd_rd_en_i;
    data_t                 fwd_rd_data_o;
    logic                  fwd_rd_data_vld_o;
    plen_t                 fwd_byte_len_o;
    logic                  fwd_done_i;
    logic                  fwd_done_ack_o;
    logic                  rdy_for_fwd_o;
    logic                  rdy_for_fwd_ack_i;

    row_t        tbl [NUM_ROWS];
    logic [31:0] seed;
    int          errors;
    int          checks;
    int          tests;
    int          limit;
    int          err_before;

    // Words written but not yet read back, and the packets still held
    data_t       exp_data_q [$];
    int          pend_words_q [$];
    plen_t       pend_len_q [$];

    p3 #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_IN     (1'b1),
        .BUF_OUT    (1'b1),
        .PESS       (1'b1)
    ) p3_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .sn_addr_i         (sn_addr_i),
        .sn_wr_data_i      (sn_wr_data_i),
        .sn_wr_en_i        (sn_wr_en_i),
        .sn_byte_inc_i     (sn_byte_inc_i),
        .sn_done_i         (sn_done_i),
        .sn_done_ack_o     (sn_done_ack_o),
        .rdy_for_sn_o      (rdy_for_sn_o),
        .rdy_for_sn_ack_i  (rdy_for_sn_ack_i),
        .fwd_addr_i        (fwd_addr_i),
        .fwd_rd_en_i       (fwd_rd_en_i),
        .fwd_rd_data_o     (fwd_rd_data_o),
        .fwd_rd_data_vld_o (fwd_rd_data_vld_o),
        .fwd_byte_len_o    (fwd_byte_len_o),
        .fwd_done_i        (fwd_done_i),
        .fwd_done_ack_o    (fwd_done_ack_o),
        .rdy_for_fwd_o     (rdy_for_fwd_o),
        .rdy_for_fwd_ack_i (rdy_for_fwd_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_data(input data_t got, input data_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input plen_t got, input plen_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        // words, increment, mode, expected length, behavior
        tbl[0] = '{8'd8,  8'd8, MODE_DRAIN,   32'd64,  3'd2};
        tbl[1] = '{8'd5,  8'd8, MODE_FILL,    32'd40,  3'd3};
        tbl[2] = '{8'd3,  8'd4, MODE_FILL,    32'd12,  3'd3};
        tbl[3] = '{8'd6,  8'd2, MODE_DRAIN,   32'd12,  3'd3};
        tbl[4] = '{8'd20, 8'd8, MODE_DRAIN,   32'd160, 3'd4};
        tbl[5] = '{8'd2,  8'd3, MODE_DRAIN,   32'd6,   3'd4};
        tbl[6] = '{8'd12, 8'd8, MODE_FILL,    32'd96,  3'd5};
        tbl[7] = '{8'd10, 8'd5, MODE_OVERLAP, 32'd50,  3'd5};
        tbl[8] = '{8'd4,  8'd1, MODE_OVERLAP, 32'd4,   3'd5};
    endtask

    task automatic fill_packet(input int row, input bit overlapped);
        int          cnt;
        int          w;
        logic [31:0] hi;
        data_t       word;
        @(negedge clk);
        cnt = 0;
        while (!rdy_for_sn_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rdy_for_sn_o) begin
            $display("ERROR at %0t: snooper ready never came for row %0d", $time, row);
            errors++;
        end
        rdy_for_sn_ack_i = 1'b1;
        for (w = 0; w < tbl[row].words; w++) begin
            @(negedge clk);
            if (w == 0)
                check_flag(rdy_for_sn_o, 1'b0, "rdy_for_sn_o after ack");
            rdy_for_sn_ack_i = 1'b0;
            seed = lcg_step(seed);
            hi   = seed;
            seed = lcg_step(seed);
            word = {hi, seed};
            exp_data_q.push_back(word);
            sn_wr_en_i    = 1'b1;
            sn_addr_i     = ADDR_WIDTH'(w);
            sn_wr_data_i  = word;
            sn_byte_inc_i = tbl[row].inc;
        end
        @(negedge clk);
        sn_wr_en_i = 1'b0;
        sn_done_i  = 1'b1;
        @(negedge clk);
        sn_done_i = 1'b0;
        // Done has just left the input stage, the ack is still one cycle away
        check_flag(sn_done_ack_o, 1'b0, "sn_done_ack_o early");
        @(negedge clk);
        check_flag(sn_done_ack_o, 1'b1, "sn_done_ack_o pulse");
        pend_words_q.push_back(int'(tbl[row].words));
        pend_len_q.push_back(tbl[row].exp_len);
        if (!overlapped)
            check_flag(rdy_for_sn_o, pend_words_q.size() < 3, "rdy_for_sn_o after fill");
        @(negedge clk);
        check_flag(sn_done_ack_o, 1'b0, "sn_done_ack_o end of pulse");
    endtask

    task automatic drain_packet();
        int    cnt;
        int    n;
        int    t;
        logic  exp_vld;
        plen_t exp_len;
        @(negedge clk);
        cnt = 0;
        while (!rdy_for_fwd_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rdy_for_fwd_o) begin
            $display("ERROR at %0t: forwarder ready never came", $time);
            errors++;
        end
        n       = pend_words_q.pop_front();
        exp_len = pend_len_q.pop_front();
        rdy_for_fwd_ack_i = 1'b1;
        // Read t shows up three negedges after it was issued
        for (t = 0; t <= n + 3; t++) begin
            @(negedge clk);
            rdy_for_fwd_ack_i = 1'b0;
            exp_vld = (t >= 3) && (t < n + 3);
            check_flag(fwd_rd_data_vld_o, exp_vld, "fwd_rd_data_vld_o");
            if (exp_vld)
                check_data(fwd_rd_data_o, exp_data_q.pop_front(), "fwd_rd_data_o");
            fwd_rd_en_i = (t < n);
            fwd_addr_i  = ADDR_WIDTH'(t);
        end
        check_len(fwd_byte_len_o, exp_len, "fwd_byte_len_o");
        check_flag(fwd_done_ack_o, 1'b0, "fwd_done_ack_o early");
        fwd_done_i = 1'b1;
        @(negedge clk);
        fwd_done_i = 1'b0;
        check_flag(fwd_done_ack_o, 1'b1, "fwd_done_ack_o pulse");
        @(negedge clk);
        check_flag(fwd_done_ack_o, 1'b0, "fwd_done_ack_o end of pulse");
    endtask

    task automatic drain_all();
        // With every buffer taken the snooper must stay locked out
        if (pend_words_q.size() == 3) begin
            repeat (4) begin
                @(negedge clk);
                check_flag(rdy_for_sn_o, 1'b0, "rdy_for_sn_o with all buffers full");
            end
        end
        while (pend_words_q.size() > 0)
            drain_packet();
    endtask

    task automatic report_test(input int num, input int behavior, input int err_start);
        tests++;
        if (errors == err_start)
            $display("test %0d (behavior %0d): ok", num, behavior);
        else
            $display("test %0d (behavior %0d): %0d errors", num, behavior, errors - err_start);
    endtask

    initial begin
        rst_n_i           = 1'b0;
        sn_addr_i         = '0;
        sn_wr_data_i      = '0;
        sn_wr_en_i        = 1'b0;
        sn_byte_inc_i     = '0;
        sn_done_i         = 1'b0;
        rdy_for_sn_ack_i  = 1'b0;
        fwd_addr_i        = '0;
        fwd_rd_en_i       = 1'b0;
        fwd_done_i        = 1'b0;
        rdy_for_fwd_ack_i = 1'b0;
        seed   = 32'd31;
        errors = 0;
        checks = 0;
        tests  = 0;
        load_table();

        limit = 200;
        for (int i = 0; i < NUM_ROWS; i++)
            limit += int'(tbl[i].words) * 10;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("ERROR: the run timed out after %0d cycles", limit);
                $display("RESULT: FAIL");
                $finish;
            end
        join_none

        repeat (3) @(negedge clk);
        err_before = errors;
        check_flag(rdy_for_fwd_o, 1'b0, "rdy_for_fwd_o in reset");
        check_flag(sn_done_ack_o, 1'b0, "sn_done_ack_o in reset");
        check_flag(fwd_done_ack_o, 1'b0, "fwd_done_ack_o in reset");
        check_flag(fwd_rd_data_vld_o, 1'b0, "fwd_rd_data_vld_o in reset");
        rst_n_i = 1'b1;
        @(negedge clk);
        check_flag(rdy_for_sn_o, 1'b1, "rdy_for_sn_o after reset");
        check_flag(rdy_for_fwd_o, 1'b0, "rdy_for_fwd_o after reset");
        report_test(0, 1, err_before);

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_before = errors;
            case (tbl[r].mode)
                MODE_FILL: fill_packet(r, 1'b0);
                MODE_DRAIN: begin
                    fill_packet(r, 1'b0);
                    drain_all();
                end
                default: begin
                    fork
                        fill_packet(r, 1'b1);
                        drain_packet();
                    join
                end
            endcase
            if (r == NUM_ROWS - 1)
                drain_all();
            report_test(r + 1, int'(tbl[r].behavior), err_before);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
common/p3_buf_pkg.sv
common/p3_ctrl_pkg.sv
p3ctrl/p3ctrl.sv
p_ng/p_ng.sv
verilog/buf_mux.sv
verilog/sn_adapter.sv
verilog/fwd_adapter.sv
verilog/p3.sv
sim/p3_tb.sv

// ==== Bender.yml ====
package:
  name: p3

sources:
  - files:
      - common/p3_buf_pkg.sv
      - common/p3_ctrl_pkg.sv
      - p3ctrl/p3ctrl.sv
      - p_ng/p_ng.sv
      - verilog/buf_mux.sv
      - verilog/sn_adapter.sv
      - verilog/fwd_adapter.sv
      - verilog/p3.sv
  - target: simulation
    files:
      - sim/p3_tb.sv
